/* all.f */
+incdir+include
logic/mci_pkg.sv
logic/mci_apb_decode.sv
logic/mci_mbox.sv
logic/mci_resp_merge.sv
logic/mci_top.sv
bench/mci_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the mailbox subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module mci_tb -f all.f > "$LOG" 2>&1 \
    && ./obj_dir/Vmci_tb >> "$LOG" 2>&1 \
    || echo "STATUS: FAIL" >> "$LOG"

cat "$LOG"
grep -q "STATUS: FAIL" "$LOG" && exit 1 || exit 0

/* include/mci_tb_tasks.svh */
// Directed tests of the mailbox subsystem
// Each test drives APB transfers through the bench tasks and
// checks the responses against the bench model
`ifndef MCI_TB_TASKS_SVH
`define MCI_TB_TASKS_SVH

    // First read takes the lock, second sees it held
    task automatic test_lock();
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            read_lock(m);
            read_lock(m);
            write_execute(m, 1'b0);
            read_lock(m);
            write_execute(m, 1'b0);
        end
    endtask

    // Distinct random words per mailbox also show there is no crosstalk
    task automatic test_data();
        logic [31:0] data;
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            read_lock(m);
        end
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            for (int w = 0; w < mci_pkg::MBOX_DEPTH; w++) begin
                data = $random(seed);
                write_word(m, w, data);
            end
        end
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            for (int w = 0; w < mci_pkg::MBOX_DEPTH; w++) begin
                read_word(m, w);
            end
            write_execute(m, 1'b0);
        end
    endtask

    task automatic test_refusal();
        logic [31:0] data;
        data = $random(seed);
        // Mailbox 0 is free here, so the write is refused
        write_word(0, 3, data);
        read_word(0, 3);
        read_expect("unmapped region read", reg_addr(5, 0), 32'h0, 1'b1);
        write_expect("unmapped region write", reg_addr(5, 0), data, 1'b1);
        read_expect("unmapped mailbox offset", reg_addr(1, 5), 32'h0, 1'b1);
        read_expect("offset past data window", reg_addr(0, 32), 32'h0, 1'b1);
        read_expect("unmapped global offset", reg_addr(mci_pkg::REGION_GLOBAL, 1), 32'h0, 1'b1);
    endtask

    task automatic test_interrupt();
        logic [mci_pkg::ADDR_W-1:0] sts_addr;
        sts_addr = reg_addr(mci_pkg::REGION_GLOBAL, mci_pkg::OFS_INTR_STATUS);
        read_lock(1);
        write_execute(1, 1'b1);
        // Low right after the completing edge, high one cycle later
        @(negedge clk);
        check_equal("mbox_intr_o", "after EXECUTE completion", {31'b0, mbox_intr}, 32'h0);
        @(negedge clk);
        check_equal("mbox_intr_o", "one cycle later", {31'b0, mbox_intr}, 32'h1);
        read_expect("INTR_STATUS set", sts_addr, 32'(sts_m), 1'b0);
        write_execute(1, 1'b0);
        read_expect("INTR_STATUS after release", sts_addr, 32'(sts_m), 1'b0);
        write_expect("INTR_STATUS clear", sts_addr, 32'h2, 1'b0);
        sts_m[1] = 1'b0;
        @(negedge clk);
        check_equal("mbox_intr_o", "after status clear", {31'b0, mbox_intr}, 32'h0);
        read_expect("INTR_STATUS cleared", sts_addr, 32'(sts_m), 1'b0);
    endtask

    // Leave every lock and a status bit set, then reset
    task automatic test_reset();
        logic [mci_pkg::ADDR_W-1:0] sts_addr;
        sts_addr = reg_addr(mci_pkg::REGION_GLOBAL, mci_pkg::OFS_INTR_STATUS);
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            read_lock(m);
        end
        write_execute(0, 1'b1);
        apply_reset();
        read_expect("INTR_STATUS after reset", sts_addr, 32'h0, 1'b0);
        check_equal("mbox_intr_o", "after reset", {31'b0, mbox_intr}, 32'h0);
        for (int m = 0; m < mci_pkg::NUM_MBOX; m++) begin
            read_lock(m);
        end
    endtask

`endif

/* bench/mci_tb.sv */
// Testbench for the mailbox subsystem
// APB read and write tasks, a model of the locks, data arrays
// and interrupt status, a cycle timeout and a closing summary
`timescale 1ns/1ps
`default_nettype none

module mci_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = 2000;

    logic                          clk;
    logic                          reset_i;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [mci_pkg::ADDR_W-1:0]    paddr;
    logic [mci_pkg::DATA_W-1:0]    pwdata;
    logic [mci_pkg::DATA_W-1:0]    prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          mbox_intr;

    // Model state
    logic [mci_pkg::NUM_MBOX-1:0]  lock_m;
    logic [mci_pkg::NUM_MBOX-1:0]  avail_m;
    logic [mci_pkg::NUM_MBOX-1:0]  sts_m;
    logic [mci_pkg::DATA_W-1:0]    mem_m [mci_pkg::NUM_MBOX][mci_pkg::MBOX_DEPTH];
    int                            seed;
    int                            errors;
    int                            checks;
    int                            cycles;

    mci_top uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .mbox_intr_o (mbox_intr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, tests did not finish", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////
    // Checks and bus access
    //////////////////////////////
    task automatic check_equal(input string sig, input string ctx,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h (%s)", sig, got, exp, ctx);
            errors++;
        end
    endtask

    function automatic logic [mci_pkg::ADDR_W-1:0] reg_addr(input int region, input int word);
        int full;
        full = (region << mci_pkg::REGION_LSB) | (word << mci_pkg::WORD_LSB);
        return full[mci_pkg::ADDR_W-1:0];
    endfunction

    // Setup then access, sampled at the falling edge of the access cycle
    task automatic apb_access(input logic write, input logic [mci_pkg::ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        checks++;
        assert (pready === 1'b1) else begin
            $display("pready_o was not high in the access cycle at address 0x%03h", addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input string ctx, input logic [mci_pkg::ADDR_W-1:0] addr,
                               input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_equal("prdata_o", ctx, rdata, exp_data);
        check_equal("pslverr_o", ctx, {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic write_expect(input string ctx, input logic [mci_pkg::ADDR_W-1:0] addr,
                                input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_equal("pslverr_o", ctx, {31'b0, err}, {31'b0, exp_err});
    endtask

    //////////////////////////////
    // Model driven accesses
    //////////////////////////////
    // A free lock reads 0 and is taken by the read
    task automatic read_lock(input int m);
        read_expect($sformatf("LOCK read mbox %0d", m), reg_addr(m, mci_pkg::OFS_LOCK),
                    {31'b0, lock_m[m]}, 1'b0);
        lock_m[m] = 1'b1;
    endtask

    task automatic write_execute(input int m, input logic go);
        write_expect($sformatf("EXECUTE write mbox %0d", m),
                     reg_addr(m, mci_pkg::OFS_EXECUTE), {31'b0, go}, 1'b0);
        if (!go) begin
            lock_m[m]  = 1'b0;
            avail_m[m] = 1'b0;
        end else if (lock_m[m]) begin
            // Status follows a rising data_avail only
            if (!avail_m[m]) begin
                sts_m[m] = 1'b1;
            end
            avail_m[m] = 1'b1;
        end
    endtask

    task automatic write_word(input int m, input int w, input logic [31:0] data);
        write_expect($sformatf("data write mbox %0d word %0d", m, w),
                     reg_addr(m, mci_pkg::OFS_DATA_BASE + w), data, ~lock_m[m]);
        if (lock_m[m]) begin
            mem_m[m][w] = data;
        end
    endtask

    task automatic read_word(input int m, input int w);
        read_expect($sformatf("data read mbox %0d word %0d", m, w),
                    reg_addr(m, mci_pkg::OFS_DATA_BASE + w), mem_m[m][w], 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        lock_m  = '0;
        avail_m = '0;
        sts_m   = '0;
    endtask

`include "mci_tb_tasks.svh"

    initial begin
        seed    = 32'hb0bd_ac53;
        errors  = 0;
        checks  = 0;
        reset_i = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        apply_reset();
        test_lock();
        test_data();
        test_refusal();
        test_interrupt();
        test_reset();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/mci_top.sv */
// Mailbox subsystem top level
// APB decoder, an array of identical mailboxes and the
// read-back and interrupt stage
`timescale 1ns/1ps
`default_nettype none

module mci_top (
    input  logic                          clk,
    input  logic                          reset_i,
    // APB subordinate
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [mci_pkg::ADDR_W-1:0]    paddr_i,
    input  logic [mci_pkg::DATA_W-1:0]    pwdata_i,
    output logic [mci_pkg::DATA_W-1:0]    prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    // Aggregated mailbox interrupt
    output logic                          mbox_intr_o
);

    logic [mci_pkg::NUM_MBOX-1:0]                      mbox_rd;
    logic [mci_pkg::NUM_MBOX-1:0]                      mbox_wr;
    logic                                              glb_rd;
    logic                                              glb_wr;
    logic [mci_pkg::WORD_W-1:0]                        word;
    logic [mci_pkg::DATA_W-1:0]                        wdata;
    logic [mci_pkg::TGT_W-1:0]                         tgt_sel;
    logic [mci_pkg::NUM_MBOX-1:0][mci_pkg::DATA_W-1:0] mbox_rdata;
    logic [mci_pkg::NUM_MBOX-1:0]                      mbox_err;
    logic [mci_pkg::NUM_MBOX-1:0]                      mbox_avail;

    mci_apb_decode u_decode (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pready_o  (pready_o),
        .mbox_rd_o (mbox_rd),
        .mbox_wr_o (mbox_wr),
        .glb_rd_o  (glb_rd),
        .glb_wr_o  (glb_wr),
        .word_o    (word),
        .wdata_o   (wdata),
        .tgt_sel_o (tgt_sel)
    );

    //////////////////////////////
    // Mailbox array
    //////////////////////////////
    for (genvar i = 0; i < mci_pkg::NUM_MBOX; i++) begin : g_mbox
        mci_mbox u_mbox (
            .clk          (clk),
            .reset_i      (reset_i),
            .rd_i         (mbox_rd[i]),
            .wr_i         (mbox_wr[i]),
            .word_i       (word),
            .wdata_i      (wdata),
            .rdata_o      (mbox_rdata[i]),
            .err_o        (mbox_err[i]),
            .data_avail_o (mbox_avail[i])
        );
    end

    mci_resp_merge u_merge (
        .clk          (clk),
        .reset_i      (reset_i),
        .tgt_sel_i    (tgt_sel),
        .glb_rd_i     (glb_rd),
        .glb_wr_i     (glb_wr),
        .word_i       (word),
        .wdata_i      (wdata),
        .mbox_rdata_i (mbox_rdata),
        .mbox_err_i   (mbox_err),
        .mbox_avail_i (mbox_avail),
        .prdata_o     (prdata_o),
        .pslverr_o    (pslverr_o),
        .mbox_intr_o  (mbox_intr_o)
    );

endmodule

`default_nettype wire

/* logic/mci_resp_merge.sv */
// Read-back and interrupt stage
// Picks read data and slave error from the selected target and
// keeps a sticky interrupt status bit per mailbox, set on each
// rising data_avail and cleared by writing 1 to INTR_STATUS.
`timescale 1ns/1ps
`default_nettype none

module mci_resp_merge (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic [mci_pkg::TGT_W-1:0]                     tgt_sel_i,
    input  logic                                          glb_rd_i,
    input  logic                                          glb_wr_i,
    input  logic [mci_pkg::WORD_W-1:0]                    word_i,
    input  logic [mci_pkg::DATA_W-1:0]                    wdata_i,
    input  logic [mci_pkg::NUM_MBOX-1:0][mci_pkg::DATA_W-1:0] mbox_rdata_i,
    input  logic [mci_pkg::NUM_MBOX-1:0]                  mbox_err_i,
    input  logic [mci_pkg::NUM_MBOX-1:0]                  mbox_avail_i,
    output logic [mci_pkg::DATA_W-1:0]                    prdata_o,
    output logic                                          pslverr_o,
    output logic                                          mbox_intr_o
);

    logic [mci_pkg::NUM_MBOX-1:0]  avail_q;
    logic [mci_pkg::NUM_MBOX-1:0]  intr_sts_q;
    logic [mci_pkg::NUM_MBOX-1:0]  sts_set;
    logic [mci_pkg::NUM_MBOX-1:0]  sts_clr;
    logic                          sts_hit;
    logic                          glb_err;

    assign sts_hit = (int'(word_i) == mci_pkg::OFS_INTR_STATUS);
    assign glb_err = (glb_rd_i | glb_wr_i) & ~sts_hit;

    //////////////////////////////
    // Read data and error
    //////////////////////////////
    always_comb begin
        prdata_o = '0;
        for (int i = 0; i < mci_pkg::NUM_MBOX; i++) begin
            if (tgt_sel_i[i]) begin
                prdata_o = mbox_rdata_i[i];
            end
        end
        if (glb_rd_i && sts_hit) begin
            prdata_o = {{(mci_pkg::DATA_W-mci_pkg::NUM_MBOX){1'b0}}, intr_sts_q};
        end
    end

    // No target in the region leaves data at 0 with an error
    assign pslverr_o = (|(tgt_sel_i[mci_pkg::NUM_MBOX-1:0] & mbox_err_i)) |
                       glb_err | tgt_sel_i[mci_pkg::TGT_NONE];

    //////////////////////////////
    // Interrupt status
    //////////////////////////////
    assign sts_set = mbox_avail_i & ~avail_q;
    assign sts_clr = (glb_wr_i && sts_hit) ? wdata_i[mci_pkg::NUM_MBOX-1:0] : '0;

    // A new rising edge wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            avail_q    <= '0;
            intr_sts_q <= '0;
        end else begin
            avail_q    <= mbox_avail_i;
            intr_sts_q <= (intr_sts_q & ~sts_clr) | sts_set;
        end
    end

    assign mbox_intr_o = |intr_sts_q;

    a_tgt_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(tgt_sel_i) && (!(glb_rd_i || glb_wr_i) || tgt_sel_i[mci_pkg::TGT_GLB]));

endmodule

`default_nettype wire

/* logic/mci_mbox.sv */
// Single mailbox
// LOCK is taken by reading it while free. EXECUTE set to 1 raises
// data_avail, EXECUTE set to 0 clears data_avail and the lock.
// Data words are writable only while locked, always readable.
`timescale 1ns/1ps
`default_nettype none

module mci_mbox (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          rd_i,
    input  logic                          wr_i,
    input  logic [mci_pkg::WORD_W-1:0]    word_i,
    input  logic [mci_pkg::DATA_W-1:0]    wdata_i,
    output logic [mci_pkg::DATA_W-1:0]    rdata_o,
    output logic                          err_o,
    output logic                          data_avail_o
);

    logic [mci_pkg::DATA_W-1:0]  mem [mci_pkg::MBOX_DEPTH];
    logic                        lock_q;
    logic                        avail_q;
    logic                        is_lock;
    logic                        is_exec;
    logic                        is_data;
    logic [31:0]                 data_ofs;
    logic [mci_pkg::IDX_W-1:0]   idx;
    logic                        take_lock;
    logic                        exec_set;
    logic                        exec_clr;
    logic                        data_wr;

    //////////////////////////////
    // Offset decode
    //////////////////////////////
    assign is_lock = (int'(word_i) == mci_pkg::OFS_LOCK);
    assign is_exec = (int'(word_i) == mci_pkg::OFS_EXECUTE);

    // Offsets below the window wrap to large values
    assign data_ofs = 32'(word_i) - 32'(mci_pkg::OFS_DATA_BASE);
    assign is_data  = (data_ofs < mci_pkg::MBOX_DEPTH);
    assign idx      = data_ofs[mci_pkg::IDX_W-1:0];

    // Read mux, returns state before this access updates it
    always_comb begin
        rdata_o = '0;
        if (is_lock) begin
            rdata_o[0] = lock_q;
        end else if (is_exec) begin
            rdata_o[0] = avail_q;
        end else if (is_data) begin
            rdata_o = mem[idx];
        end
    end

    // Unmapped offset, or data write without the lock
    assign err_o = ((rd_i | wr_i) & ~(is_lock | is_exec | is_data)) |
                   (wr_i & is_data & ~lock_q);

    //////////////////////////////
    // Lock and execute
    //////////////////////////////
    assign take_lock = rd_i & is_lock & ~lock_q;
    assign exec_set  = wr_i & is_exec & wdata_i[0] & lock_q;
    assign exec_clr  = wr_i & is_exec & ~wdata_i[0];
    assign data_wr   = wr_i & is_data & lock_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            lock_q  <= 1'b0;
            avail_q <= 1'b0;
        end else begin
            if (take_lock) begin
                lock_q <= 1'b1;
            end else if (exec_clr) begin
                lock_q <= 1'b0;
            end
            if (exec_set) begin
                avail_q <= 1'b1;
            end else if (exec_clr) begin
                avail_q <= 1'b0;
            end
        end
    end

    // Data array
    always_ff @(posedge clk) begin
        if (data_wr) begin
            mem[idx] <= wdata_i;
        end
    end

    assign data_avail_o = avail_q;

    // Only an EXECUTE write by the lock holder raises the flag
    a_avail_locked: assert property (@(posedge clk) disable iff (reset_i)
        $rose(avail_q) |-> lock_q && $past(wr_i));

endmodule

`default_nettype wire

/* logic/mci_apb_decode.sv */
// APB subordinate front end of the mailbox subsystem
// Zero wait states, so every access phase completes at once.
// Splits each transfer into per-target read and write strobes
// and a one-hot target select for the read-back stage.
`timescale 1ns/1ps
`default_nettype none

module mci_apb_decode (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [mci_pkg::ADDR_W-1:0]         paddr_i,
    input  logic [mci_pkg::DATA_W-1:0]         pwdata_i,
    output logic                               pready_o,
    output logic [mci_pkg::NUM_MBOX-1:0]       mbox_rd_o,
    output logic [mci_pkg::NUM_MBOX-1:0]       mbox_wr_o,
    output logic                               glb_rd_o,
    output logic                               glb_wr_o,
    output logic [mci_pkg::WORD_W-1:0]         word_o,
    output logic [mci_pkg::DATA_W-1:0]         wdata_o,
    output logic [mci_pkg::TGT_W-1:0]          tgt_sel_o
);

    logic                           access;
    logic                           access_q;
    logic [mci_pkg::REGION_W-1:0]   region;
    logic [mci_pkg::NUM_MBOX-1:0]   mbox_hit;
    logic                           glb_hit;

    // Access phase of a transfer
    assign access   = psel_i & penable_i;
    assign pready_o = access;

    assign region  = paddr_i[mci_pkg::ADDR_W-1:mci_pkg::REGION_LSB];
    assign word_o  = paddr_i[mci_pkg::REGION_LSB-1:mci_pkg::WORD_LSB];
    assign wdata_o = pwdata_i;

    //////////////////////////////
    // Region decode
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < mci_pkg::NUM_MBOX; i++) begin
            mbox_hit[i] = (int'(region) == i);
        end
    end

    assign glb_hit = (int'(region) == mci_pkg::REGION_GLOBAL);

    // All zero outside an access phase
    always_comb begin
        tgt_sel_o = '0;
        if (access) begin
            tgt_sel_o[mci_pkg::NUM_MBOX-1:0] = mbox_hit;
            tgt_sel_o[mci_pkg::TGT_GLB]      = glb_hit;
            tgt_sel_o[mci_pkg::TGT_NONE]     = ~(|mbox_hit | glb_hit);
        end
    end

    assign mbox_rd_o = (access && !pwrite_i) ? mbox_hit : '0;
    assign mbox_wr_o = (access && pwrite_i) ? mbox_hit : '0;
    assign glb_rd_o  = access & ~pwrite_i & glb_hit;
    assign glb_wr_o  = access & pwrite_i & glb_hit;

    // Set for the cycle after a setup phase
    always_ff @(posedge clk) begin
        if (reset_i) begin
            access_q <= 1'b0;
        end else begin
            access_q <= psel_i & ~penable_i;
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////
    a_ready_after_setup: assert property (@(posedge clk) disable iff (reset_i)
        pready_o |-> psel_i && access_q);

    // One target per transfer, and only for one cycle
    a_strobe_pulse: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({mbox_rd_o, mbox_wr_o, glb_rd_o, glb_wr_o}) and
        ((|{mbox_rd_o, mbox_wr_o, glb_rd_o, glb_wr_o}) |=>
            !(|{mbox_rd_o, mbox_wr_o, glb_rd_o, glb_wr_o})));

endmodule

`default_nettype wire

/* logic/mci_pkg.sv */
// Mailbox subsystem shared definitions
// Bus widths, the APB address map and the mailbox register offsets
`default_nettype none

package mci_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    // Mailbox array
    localparam int NUM_MBOX   = 2;
    localparam int MBOX_DEPTH = 16;
    localparam int IDX_W      = $clog2(MBOX_DEPTH);

    //////////////////////////////
    // Address map
    //////////////////////////////
    // Byte address, region in the top bits, word offset below it
    localparam int WORD_W        = 6;
    localparam int REGION_LSB    = 8;
    localparam int REGION_W      = ADDR_W - REGION_LSB;
    localparam int WORD_LSB      = REGION_LSB - WORD_W;
    localparam int REGION_GLOBAL = 15;

    // Word offsets in a mailbox region
    localparam int OFS_LOCK      = 0;
    localparam int OFS_EXECUTE   = 1;
    localparam int OFS_DATA_BASE = 16;

    // Word offsets in the global region
    localparam int OFS_INTR_STATUS = 0;

    // One-hot target select, mailboxes first, then global, then none
    localparam int TGT_W    = NUM_MBOX + 2;
    localparam int TGT_GLB  = NUM_MBOX;
    localparam int TGT_NONE = NUM_MBOX + 1;

endpackage

`default_nettype wire
